//--- files.f
+incdir+source
source/cornet_pkg.sv
source/cornet_control.sv
source/cornet_bus_unit.sv
source/cornet_memory.sv
source/cornet_system.sv
dv/cornet_tb_checks.sv
dv/cornet_tb.sv

//--- dv/cornet_tb.sv
module cornet_tb;
   timeunit 1ns;
   timeprecision 1ps;

   logic              clk = 1'b0;
   logic              reset_n;
   logic              load_en;
   cornet_pkg::addr_t load_addr;
   cornet_pkg::byte_t load_data;
   cornet_pkg::addr_t addr;
   logic              rd_req;
   logic              wr_en;
   cornet_pkg::byte_t wr_data;

   // older entries of the memory image are turned into zeros so each test clears them
   cornet_pkg::addr_t img_addr [$];
   cornet_pkg::byte_t img_data [$];
   cornet_pkg::addr_t here;
   string             cur_name;
   int                errors_before;
   int                tests_run = 0;
   int                tests_failed = 0;

   cornet_system cornet_system_inst (
      .clk       (clk),
      .reset_n   (reset_n),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data),
      .addr      (addr),
      .rd_req    (rd_req),
      .wr_en     (wr_en),
      .wr_data   (wr_data)
   );

   cornet_tb_checks cornet_tb_checks_inst (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_req  (rd_req),
      .wr_en   (wr_en),
      .wr_data (wr_data)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   task automatic put(input cornet_pkg::addr_t a, input cornet_pkg::byte_t d);
      img_addr.push_back(a);
      img_data.push_back(d);
   endtask

   task automatic emit(input cornet_pkg::byte_t d);
      put(here, d);
      here = here + 16'd1;
   endtask

   task automatic emit_word(input cornet_pkg::addr_t w);
      emit(w[7:0]);
      emit(w[15:8]);
   endtask

   // JMP to itself keeps the CPU parked once the program is done
   task automatic emit_halt();
      cornet_pkg::addr_t t;
      t = here;
      emit(8'h4C);
      emit_word(t);
   endtask

   function automatic cornet_pkg::addr_t rand_ram();
      return 16'h1000 + 16'($urandom % 16'h6000);
   endfunction

   // **************************************************************************
   // test sequencing
   // **************************************************************************
   task automatic start_test(input string name, input cornet_pkg::addr_t org);
      @(posedge clk);
      reset_n <= 1'b0;
      @(posedge clk);
      cornet_tb_checks_inst.clear_expectations();
      cornet_tb_checks_inst.post_vector(org);
      foreach (img_data[i]) img_data[i] = 8'h00;
      cur_name      = name;
      errors_before = cornet_tb_checks_inst.errors();
      here          = org;
      put(16'hFFFC, org[7:0]);
      put(16'hFFFD, org[15:8]);
   endtask

   task automatic release_reset();
      foreach (img_addr[i]) begin
         load_en   <= 1'b1;
         load_addr <= img_addr[i];
         load_data <= img_data[i];
         @(posedge clk);
      end
      load_en <= 1'b0;
      repeat (3) @(posedge clk);
      reset_n <= 1'b1;
   endtask

   task automatic finish_test();
      int cycles;
      int new_errors;
      cycles = 0;
      while (cornet_tb_checks_inst.pending_writes() != 0 && cycles < 3000) begin
         @(posedge clk);
         cycles++;
      end
      // extra cycles let a late or skipped store show up
      repeat (20) @(posedge clk);
      new_errors = cornet_tb_checks_inst.errors() - errors_before;
      tests_run++;
      if (cornet_tb_checks_inst.pending_writes() != 0) begin
         tests_failed++;
         $display("%s: timed out, the write to %h never came", cur_name,
                  cornet_tb_checks_inst.next_write_addr());
      end else if (new_errors != 0) begin
         tests_failed++;
         $display("%s: %0d errors", cur_name, new_errors);
      end else begin
         $display("%s: ok", cur_name);
      end
   endtask

   initial begin
      cornet_pkg::addr_t a1;
      cornet_pkg::addr_t a2;
      cornet_pkg::addr_t loop;
      cornet_pkg::byte_t v;
      cornet_pkg::byte_t x;
      cornet_pkg::byte_t d;
      reset_n   = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      void'($urandom(32'hd272));

      start_test("reset_vector", 16'h0200 + 16'($urandom % 16'h0D00));
      v  = 8'($urandom);
      a1 = rand_ram();
      emit(8'hA9);
      emit(v);
      emit(8'h8D);
      emit_word(a1);
      emit_halt();
      cornet_tb_checks_inst.post_write(a1, v);
      release_reset();
      finish_test();

      start_test("lda_sta", 16'h0200);
      v  = 8'($urandom);
      a1 = rand_ram();
      emit(8'hA9);
      emit(v);
      emit(8'h8D);
      emit_word(a1);
      emit_halt();
      cornet_tb_checks_inst.post_write(a1, v);
      release_reset();
      finish_test();

      // the table byte read at a1+x lands at a2+x
      start_test("indexed", 16'h0240);
      x  = 8'($urandom);
      d  = 8'($urandom);
      a1 = 16'h1000 | 16'($urandom & 16'h0FFF);
      a2 = 16'h4000 | 16'($urandom & 16'h0FFF);
      put(a1 + x, d);
      emit(8'hA2);
      emit(x);
      emit(8'hBD);
      emit_word(a1);
      emit(8'h9D);
      emit_word(a2);
      emit_halt();
      cornet_tb_checks_inst.post_write(a2 + x, d);
      release_reset();
      finish_test();

      start_test("counting_loop", 16'h0280);
      v  = 8'($urandom);
      a1 = 16'h3000 | 16'($urandom & 16'h0F00);
      emit(8'hA9);
      emit(v);
      emit(8'hA2);
      emit(8'hF8);
      loop = here;
      emit(8'h9D);
      emit_word(a1);
      emit(8'hE8);
      emit(8'hD0);
      emit(8'(loop - (here + 16'd1)));
      // BEQ jumps over the marker store at 6000
      emit(8'hF0);
      emit(8'h03);
      emit(8'h8D);
      emit_word(16'h6000);
      emit(8'h8D);
      emit_word(16'h6001);
      emit_halt();
      for (int k = 8'hF8; k <= 8'hFF; k++) begin
         cornet_tb_checks_inst.post_write(a1 + 16'(k), v);
      end
      cornet_tb_checks_inst.post_write(16'h6001, v);
      cornet_tb_checks_inst.post_forbidden(16'h6000);
      release_reset();
      finish_test();

      start_test("jmp", 16'h0300);
      v  = 8'($urandom);
      a1 = rand_ram();
      a2 = a1 ^ 16'h0800;
      emit(8'hA9);
      emit(v);
      emit(8'h4C);
      emit_word(here + 16'd5);
      emit(8'h8D);
      emit_word(a2);
      emit(8'h8D);
      emit_word(a1);
      emit_halt();
      cornet_tb_checks_inst.post_write(a1, v);
      cornet_tb_checks_inst.post_forbidden(a2);
      release_reset();
      finish_test();

      // 02, 12, 22 and 32 are all outside the supported set
      start_test("unknown_opcode", 16'h0340);
      v  = 8'($urandom);
      a1 = rand_ram();
      emit(8'hA9);
      emit(v);
      emit(8'h02 + 8'(($urandom % 4) * 16));
      emit(8'h8D);
      emit_word(a1);
      emit_halt();
      cornet_tb_checks_inst.post_write(a1, v);
      release_reset();
      finish_test();

      $display("tests %0d, failing %0d, errors %0d", tests_run, tests_failed,
               cornet_tb_checks_inst.errors());
      if (tests_failed == 0 && cornet_tb_checks_inst.errors() == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- dv/cornet_tb_checks.sv
module cornet_tb_checks (
   input logic              clk,
   input logic              reset_n,
   input cornet_pkg::addr_t addr,
   input logic              rd_req,
   input logic              wr_en,
   input cornet_pkg::byte_t wr_data
);
   timeunit 1ns;
   timeprecision 1ps;

   cornet_pkg::addr_t exp_addr [$];
   cornet_pkg::byte_t exp_data [$];
   cornet_pkg::addr_t vector = '0;
   cornet_pkg::addr_t forbid_addr = '0;
   logic              forbid_en = 1'b0;
   int                read_count = 0;
   int                error_count = 0;
   cornet_pkg::addr_t want_addr;
   cornet_pkg::byte_t want_data;

   task automatic clear_expectations();
      exp_addr.delete();
      exp_data.delete();
      forbid_en = 1'b0;
   endtask

   task automatic post_vector(input cornet_pkg::addr_t value);
      vector = value;
   endtask

   task automatic post_write(input cornet_pkg::addr_t a, input cornet_pkg::byte_t d);
      exp_addr.push_back(a);
      exp_data.push_back(d);
   endtask

   task automatic post_forbidden(input cornet_pkg::addr_t a);
      forbid_addr = a;
      forbid_en   = 1'b1;
   endtask

   function automatic int pending_writes();
      return exp_addr.size();
   endfunction

   function automatic cornet_pkg::addr_t next_write_addr();
      return (exp_addr.size() != 0) ? exp_addr[0] : 16'h0000;
   endfunction

   function automatic int errors();
      return error_count;
   endfunction

   task automatic report_read(input cornet_pkg::addr_t want);
      error_count++;
      $display("Fail at %0t: read %0d after reset went to %h, expected %h",
               $time, read_count, addr, want);
   endtask

   // **************************************************************************
   // the first reads after reset go to the vector low byte, the vector high byte and the opcode
   // **************************************************************************
   always @(posedge clk) begin
      if (!reset_n) begin
         read_count = 0;
      end else if (rd_req) begin
         case (read_count)
            0: assert (addr == 16'hFFFC) else report_read(16'hFFFC);
            1: assert (addr == 16'hFFFD) else report_read(16'hFFFD);
            2: assert (addr == vector) else report_read(vector);
            default: ;
         endcase
         read_count++;
      end
   end

   // writes must arrive in the posted order with the posted values
   always @(posedge clk) begin
      if (reset_n && wr_en) begin
         assert (exp_addr.size() != 0) else begin
            error_count++;
            $display("Write of %h to %h arrived when no write was expected", wr_data, addr);
         end
         if (exp_addr.size() != 0) begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            assert (addr == want_addr && wr_data == want_data) else begin
               error_count++;
               $display("Fail at %0t: write of %h to %h, expected %h to %h",
                        $time, wr_data, addr, want_data, want_addr);
            end
         end
      end
   end

   forbidden_write: assert property (@(posedge clk) disable iff (!reset_n)
      !(forbid_en && wr_en && addr == forbid_addr))
   else begin
      error_count++;
      $display("Fail at %0t: write of %h to skipped address %h", $time, wr_data, forbid_addr);
   end

endmodule

//--- source/cornet_system.sv
`include "cornet_settings.svh"

module cornet_system (
   input  logic              clk,
   input  logic              reset_n,
   input  logic              load_en,
   input  cornet_pkg::addr_t load_addr,
   input  cornet_pkg::byte_t load_data,
   output cornet_pkg::addr_t addr,
   output logic              rd_req,
   output logic              wr_en,
   output cornet_pkg::byte_t wr_data
);

   // CPU side request lines
   logic              rd_byte_req;
   logic              rd_word_req;
   logic              wr_req;
   cornet_pkg::addr_t req_addr;
   cornet_pkg::byte_t req_wr_data;
   logic              rd_ack;
   cornet_pkg::byte_t rd_byte;
   cornet_pkg::word_t rd_word;

   // memory return path
   logic              ready;
   cornet_pkg::byte_t rd_data;

   cornet_control cornet_control_inst (
      .clk         (clk),
      .reset_n     (reset_n),
      .rd_byte_req (rd_byte_req),
      .rd_word_req (rd_word_req),
      .wr_req      (wr_req),
      .req_addr    (req_addr),
      .req_wr_data (req_wr_data),
      .rd_ack      (rd_ack),
      .rd_byte     (rd_byte),
      .rd_word     (rd_word)
   );

   cornet_bus_unit cornet_bus_unit_inst (
      .clk         (clk),
      .reset_n     (reset_n),
      .rd_byte_req (rd_byte_req),
      .rd_word_req (rd_word_req),
      .wr_req      (wr_req),
      .req_addr    (req_addr),
      .req_wr_data (req_wr_data),
      .rd_ack      (rd_ack),
      .rd_byte     (rd_byte),
      .rd_word     (rd_word),
      .addr        (addr),
      .rd_req      (rd_req),
      .wr_en       (wr_en),
      .wr_data     (wr_data),
      .ready       (ready),
      .rd_data     (rd_data)
   );

   cornet_memory cornet_memory_inst (
      .clk       (clk),
      .addr      (addr),
      .rd_req    (rd_req),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .ready     (ready),
      .rd_data   (rd_data),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

endmodule

//--- source/cornet_memory.sv
`include "cornet_settings.svh"

module cornet_memory (
   input  logic              clk,
   input  cornet_pkg::addr_t addr,
   input  logic              rd_req,
   input  logic              wr_en,
   input  cornet_pkg::byte_t wr_data,
   output logic              ready,
   output cornet_pkg::byte_t rd_data,
   input  logic              load_en,
   input  cornet_pkg::addr_t load_addr,
   input  cornet_pkg::byte_t load_data
);

   localparam int latency = `CORNET_MEM_LATENCY;

   cornet_pkg::byte_t mem [0:`CORNET_MEM_BYTES-1];

   // one stage per cycle of read latency
   logic [latency-1:0] ready_sr = '0;
   cornet_pkg::addr_t  addr_sr [latency];

   // ************************************************************************
   // read pipeline
   // ************************************************************************

   always_ff @(posedge clk) begin
      ready_sr[0] <= rd_req;
      addr_sr[0]  <= addr;
      for (int i = 1; i < latency; i++) begin
         ready_sr[i] <= ready_sr[i-1];
         addr_sr[i]  <= addr_sr[i-1];
      end
   end

   // ready and data come out of the last stage together
   assign ready   = ready_sr[latency-1];
   assign rd_data = mem[addr_sr[latency-1]];

   // ************************************************************************
   // writes and test loads
   // ************************************************************************

   // the load port wins when both are active
   always_ff @(posedge clk) begin
      if (load_en) begin
         mem[load_addr] <= load_data;
      end else if (wr_en) begin
         mem[addr] <= wr_data;
      end
   end

endmodule

//--- source/cornet_bus_unit.sv
`include "cornet_settings.svh"

module cornet_bus_unit (
   input  logic              clk,
   input  logic              reset_n,
   input  logic              rd_byte_req,
   input  logic              rd_word_req,
   input  logic              wr_req,
   input  cornet_pkg::addr_t req_addr,
   input  cornet_pkg::byte_t req_wr_data,
   output logic              rd_ack,
   output cornet_pkg::byte_t rd_byte,
   output cornet_pkg::word_t rd_word,
   output cornet_pkg::addr_t addr,
   output logic              rd_req,
   output logic              wr_en,
   output cornet_pkg::byte_t wr_data,
   input  logic              ready,
   input  cornet_pkg::byte_t rd_data
);

   cornet_pkg::bus_state_t state;
   cornet_pkg::addr_t      addr_q;
   logic                   rd_high_q;
   logic                   start_rd;

   // ************************************************************************
   // memory bus outputs
   // ************************************************************************

   // the first read of a request goes out in the strobe cycle itself
   assign start_rd = (state == cornet_pkg::idle) && (rd_byte_req || rd_word_req);

   assign rd_req = start_rd || rd_high_q;
   assign addr   = start_rd ? req_addr : addr_q;

   // ************************************************************************
   // request sequencer
   // ************************************************************************

   always_ff @(posedge clk) begin
      rd_ack    <= 1'b0;
      rd_high_q <= 1'b0;
      wr_en     <= 1'b0;
      if (!reset_n) begin
         state <= cornet_pkg::idle;
      end else begin
         case (state)
            cornet_pkg::idle: begin
               if (rd_byte_req) begin
                  addr_q <= req_addr;
                  state  <= cornet_pkg::byte_wait;
               end else if (rd_word_req) begin
                  addr_q <= req_addr;
                  state  <= cornet_pkg::word_low_wait;
               end else if (wr_req) begin
                  addr_q  <= req_addr;
                  wr_data <= req_wr_data;
                  wr_en   <= 1'b1;
               end
            end

            cornet_pkg::byte_wait: begin
               if (ready) begin
                  rd_byte <= rd_data;
                  rd_ack  <= 1'b1;
                  state   <= cornet_pkg::idle;
               end
            end

            // with the low byte in hand the high byte is read at the next address
            cornet_pkg::word_low_wait: begin
               if (ready) begin
                  rd_word[7:0] <= rd_data;
                  addr_q       <= addr_q + 16'd1;
                  rd_high_q    <= 1'b1;
                  state        <= cornet_pkg::word_high_wait;
               end
            end

            cornet_pkg::word_high_wait: begin
               if (ready) begin
                  rd_word[15:8] <= rd_data;
                  rd_ack        <= 1'b1;
                  state         <= cornet_pkg::idle;
               end
            end

            default: begin
               state <= cornet_pkg::idle;
            end
         endcase
      end
   end

endmodule

//--- source/cornet_control.sv
`include "cornet_settings.svh"

module cornet_control (
   input  logic              clk,
   input  logic              reset_n,
   output logic              rd_byte_req,
   output logic              rd_word_req,
   output logic              wr_req,
   output cornet_pkg::addr_t req_addr,
   output cornet_pkg::byte_t req_wr_data,
   input  logic              rd_ack,
   input  cornet_pkg::byte_t rd_byte,
   input  cornet_pkg::word_t rd_word
);

   // ************************************************************************
   // opcodes outside this set run as one byte no-ops
   // ************************************************************************

   localparam cornet_pkg::byte_t op_lda_imm = 8'hA9;
   localparam cornet_pkg::byte_t op_ldx_imm = 8'hA2;
   localparam cornet_pkg::byte_t op_sta_abs = 8'h8D;
   localparam cornet_pkg::byte_t op_sta_abx = 8'h9D;
   localparam cornet_pkg::byte_t op_lda_abx = 8'hBD;
   localparam cornet_pkg::byte_t op_inx     = 8'hE8;
   localparam cornet_pkg::byte_t op_jmp_abs = 8'h4C;
   localparam cornet_pkg::byte_t op_bne     = 8'hD0;
   localparam cornet_pkg::byte_t op_beq     = 8'hF0;

   cornet_pkg::seq_state_t state;
   cornet_pkg::addr_t      pc;
   cornet_pkg::byte_t      opcode;
   cornet_pkg::byte_t      reg_a;
   cornet_pkg::byte_t      reg_x;
   logic                   flag_z;

   cornet_pkg::addr_t      pc_inc1;
   cornet_pkg::addr_t      pc_inc2;
   cornet_pkg::addr_t      pc_inc3;
   cornet_pkg::addr_t      branch_target;
   cornet_pkg::addr_t      indexed_addr;
   cornet_pkg::byte_t      x_inc;
   logic                   branch_taken;

   assign pc_inc1 = pc + 16'd1;
   assign pc_inc2 = pc + 16'd2;
   assign pc_inc3 = pc + 16'd3;

   // the branch offset counts from the byte after the two byte branch
   assign branch_target = pc_inc2 + {{8{rd_byte[7]}}, rd_byte};

   assign indexed_addr = rd_word + {8'h00, reg_x};
   assign x_inc        = reg_x + 8'd1;

   // only looked at while the opcode is BNE or BEQ
   assign branch_taken = (opcode == op_bne) ? !flag_z : flag_z;

   always_ff @(posedge clk) begin
      rd_byte_req <= 1'b0;
      rd_word_req <= 1'b0;
      wr_req      <= 1'b0;
      if (!reset_n) begin
         state  <= cornet_pkg::reset_wait;
         reg_a  <= '0;
         reg_x  <= '0;
         flag_z <= 1'b0;
      end else begin
         case (state)
            cornet_pkg::reset_wait: begin
               req_addr    <= `CORNET_RESET_VECTOR;
               rd_word_req <= 1'b1;
               state       <= cornet_pkg::vector_read;
            end

            cornet_pkg::vector_read: begin
               if (rd_ack) begin
                  pc    <= rd_word;
                  state <= cornet_pkg::fetch;
               end
            end

            cornet_pkg::fetch: begin
               req_addr    <= pc;
               rd_byte_req <= 1'b1;
               state       <= cornet_pkg::fetch_wait;
            end

            cornet_pkg::fetch_wait: begin
               if (rd_ack) begin
                  opcode <= rd_byte;
                  state  <= cornet_pkg::execute;
               end
            end

            // ***************************************************************
            // decode and start the operand read where one is needed
            // ***************************************************************
            cornet_pkg::execute: begin
               case (opcode)
                  op_lda_imm, op_ldx_imm: begin
                     req_addr    <= pc_inc1;
                     rd_byte_req <= 1'b1;
                     state       <= cornet_pkg::operand_wait;
                  end
                  op_sta_abs, op_sta_abx, op_lda_abx, op_jmp_abs: begin
                     req_addr    <= pc_inc1;
                     rd_word_req <= 1'b1;
                     state       <= cornet_pkg::operand_wait;
                  end
                  op_inx: begin
                     reg_x  <= x_inc;
                     flag_z <= (x_inc == 8'h00);
                     pc     <= pc_inc1;
                     state  <= cornet_pkg::fetch;
                  end
                  op_bne, op_beq: begin
                     if (branch_taken) begin
                        req_addr    <= pc_inc1;
                        rd_byte_req <= 1'b1;
                        state       <= cornet_pkg::operand_wait;
                     end else begin
                        pc    <= pc_inc2;
                        state <= cornet_pkg::fetch;
                     end
                  end
                  default: begin
                     pc    <= pc_inc1;
                     state <= cornet_pkg::fetch;
                  end
               endcase
            end

            cornet_pkg::operand_wait: begin
               if (rd_ack) begin
                  case (opcode)
                     op_lda_imm: begin
                        reg_a  <= rd_byte;
                        flag_z <= (rd_byte == 8'h00);
                        pc     <= pc_inc2;
                        state  <= cornet_pkg::fetch;
                     end
                     op_ldx_imm: begin
                        reg_x  <= rd_byte;
                        flag_z <= (rd_byte == 8'h00);
                        pc     <= pc_inc2;
                        state  <= cornet_pkg::fetch;
                     end
                     op_sta_abs: begin
                        req_addr    <= rd_word;
                        req_wr_data <= reg_a;
                        wr_req      <= 1'b1;
                        pc          <= pc_inc3;
                        state       <= cornet_pkg::access_wait;
                     end
                     op_sta_abx: begin
                        req_addr    <= indexed_addr;
                        req_wr_data <= reg_a;
                        wr_req      <= 1'b1;
                        pc          <= pc_inc3;
                        state       <= cornet_pkg::access_wait;
                     end
                     op_lda_abx: begin
                        req_addr    <= indexed_addr;
                        rd_byte_req <= 1'b1;
                        pc          <= pc_inc3;
                        state       <= cornet_pkg::access_wait;
                     end
                     op_jmp_abs: begin
                        pc    <= rd_word;
                        state <= cornet_pkg::fetch;
                     end
                     default: begin
                        // taken BNE or BEQ
                        pc    <= branch_target;
                        state <= cornet_pkg::fetch;
                     end
                  endcase
               end
            end

            // a store is complete one cycle after its request
            cornet_pkg::access_wait: begin
               if (opcode == op_lda_abx) begin
                  if (rd_ack) begin
                     reg_a  <= rd_byte;
                     flag_z <= (rd_byte == 8'h00);
                     state  <= cornet_pkg::fetch;
                  end
               end else begin
                  state <= cornet_pkg::fetch;
               end
            end

            default: begin
               state <= cornet_pkg::reset_wait;
            end
         endcase
      end
   end

endmodule

//--- source/cornet_pkg.sv
`include "cornet_settings.svh"

package cornet_pkg;

   // ************************************************************************
   // data widths
   // ************************************************************************

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;

   // two bytes read low first, as the 6502 stores vectors and operands
   typedef logic [15:0] word_t;

   // ************************************************************************
   // state machines
   // ************************************************************************

   // instruction sequencer in cornet_control
   typedef enum logic [2:0] {
      reset_wait,
      vector_read,
      fetch,
      fetch_wait,
      execute,
      operand_wait,
      access_wait
   } seq_state_t;

   // memory cycle sequencer in cornet_bus_unit
   typedef enum logic [1:0] {
      idle,
      byte_wait,
      word_low_wait,
      word_high_wait
   } bus_state_t;

endpackage

//--- source/cornet_settings.svh
`ifndef CORNET_SETTINGS_SVH
`define CORNET_SETTINGS_SVH

// ***************************************************************************
// system settings shared by the CPU, the bus unit and the memory
// ***************************************************************************

// address of the low byte of the reset vector
`define CORNET_RESET_VECTOR 16'hFFFC

// a memory read takes this many cycles from request to ready and may be set from 1 to 7
`define CORNET_MEM_LATENCY 2

// the memory covers the whole 16 bit address space
`define CORNET_MEM_BYTES 65536

`endif
